// File: bcd_seg_decoder.sv
// --------------------
// BCD to seven-segment decoder with lamp test and ripple blanking
// --------------------
`timescale 1ns/1ps

module bcd_seg_decoder (
	input  display_pkg::bcd_t digit,
	input  logic              lamp_test,
	input  logic              blank_in,
	input  logic              rbi,
	output display_pkg::seg_t seg,
	output logic              rbo
);
	import display_pkg::*;

	// Glyph lookup for the plain digit value
	seg_t glyph;

	// High when the digit holds a zero
	logic is_zero;

	assign is_zero = (digit == 4'd0);

	// Glyph table of the classic part, all codes active low
	// Codes 10 to 14 give the odd partial shapes and code 15 stays dark
	always_comb begin
		unique case (digit)
			4'd0:    glyph = 7'b000_0001;
			4'd1:    glyph = 7'b100_1111;
			4'd2:    glyph = 7'b001_0010;
			4'd3:    glyph = 7'b000_0110;
			4'd4:    glyph = 7'b100_1100;
			4'd5:    glyph = 7'b010_0100;
			4'd6:    glyph = 7'b110_0000;
			4'd7:    glyph = 7'b000_1111;
			4'd8:    glyph = 7'b000_0000;
			4'd9:    glyph = 7'b000_1100;
			4'd10:   glyph = 7'b111_0010;
			4'd11:   glyph = 7'b110_0110;
			4'd12:   glyph = 7'b101_1100;
			4'd13:   glyph = 7'b011_0100;
			4'd14:   glyph = 7'b111_0000;
			default: glyph = SEG_OFF;
		endcase
	end

	// Blanking has the highest priority, then lamp test, then ripple blanking
	always_comb begin
		if (blank_in) begin
			seg = SEG_OFF;
		end else if (lamp_test) begin
			// All segments lit
			seg = '0;
		end else if (!rbi && is_zero) begin
			// A suppressed leading zero goes dark
			seg = SEG_OFF;
		end else begin
			seg = glyph;
		end
	end

	// The zero is passed down the chain only while it is itself suppressed
	// Lamp test keeps every lower digit from blanking
	assign rbo = !(!lamp_test && !rbi && is_zero);

endmodule

// File: blanking_chain.sv
// --------------------
// Decoder chain with ripple blanking from the top digit down
// --------------------
`timescale 1ns/1ps

module blanking_chain (
	display_cfg_if.chain      cfg,
	output display_pkg::seg_t patterns [display_pkg::NUM_DIGITS]
);
	import display_pkg::*;

	// Ripple blanking into and out of every decoder, active low
	logic rbi [NUM_DIGITS];
	logic rbo [NUM_DIGITS];

	generate
		for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit

			// The top digit starts the chain when suppression is enabled
			// Digit zero always shows so an all-zero value still reads 0
			// Every other digit listens to the digit above it
			if (i == NUM_DIGITS - 1) begin : g_top
				assign rbi[i] = !cfg.zero_suppress;
			end else if (i == 0) begin : g_last
				assign rbi[i] = 1'b1;
			end else begin : g_mid
				assign rbi[i] = rbo[i + 1];
			end

			bcd_seg_decoder u_dec (
				.digit     (cfg.digits[i]),
				.lamp_test (cfg.lamp_test),
				.blank_in  (cfg.blank_all),
				.rbi       (rbi[i]),
				.seg       (patterns[i]),
				.rbo       (rbo[i])
			);
		end
	endgenerate

	// The ripple outputs of digits one and zero reach no lower decoder
	// that listens, since digit zero ignores the chain

endmodule

// File: display_cfg_if.sv
// --------------------
// Configuration bundle from the register block to the blanking chain
// --------------------
`timescale 1ns/1ps

interface display_cfg_if;
	import display_pkg::*;

	// Stored BCD value of every digit
	bcd_t digits [NUM_DIGITS];

	// Lights every segment on every digit
	logic lamp_test;

	// Darkens the whole display, wins over lamp test
	logic blank_all;

	// Enables leading zero suppression from the top digit down
	logic zero_suppress;

	// The register block owns every signal of the bundle
	modport regs (
		output digits,
		output lamp_test,
		output blank_all,
		output zero_suppress
	);

	// The decoder chain only reads the configuration
	modport chain (
		input digits,
		input lamp_test,
		input blank_all,
		input zero_suppress
	);

endinterface

// File: display_pkg.sv
// --------------------
// Shared constants and types for the four-digit seven-segment driver
// --------------------
package display_pkg;

	// Number of digits on the display, digit zero is the least significant
	localparam int NUM_DIGITS = 4;

	// Clock cycles each digit stays selected by the scanner
	localparam int SCAN_DIV = 4;

	// Width of the host write address
	localparam int ADDR_W = 3;

	// Addresses zero to three select the digit registers
	// The control register sits right above them
	localparam int CTRL_ADDR = 4;

	// Bit positions inside the control register
	localparam int CTRL_LAMP_TEST = 0;
	localparam int CTRL_BLANK = 1;
	localparam int CTRL_ZERO_SUPPRESS = 2;

	// One BCD code, codes 10 to 15 are legal and show special glyphs
	typedef logic [3:0] bcd_t;

	// Segment pattern with segment a in bit 6 down to segment g in bit 0
	// The bus is active low, so a zero bit lights its segment
	typedef logic [6:0] seg_t;

	// Every segment dark
	localparam seg_t SEG_OFF = 7'b111_1111;

endpackage

// File: display_regs.sv
// --------------------
// Host register block for the digit values and the display controls
// --------------------
`timescale 1ns/1ps

module display_regs (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           wr_en,
	input  logic [display_pkg::ADDR_W-1:0] wr_addr,
	input  logic [7:0]                     wr_data,
	display_cfg_if.regs                    cfg
);
	import display_pkg::*;

	// Decoded write to the control register
	logic ctrl_wr;

	assign ctrl_wr = wr_en && (wr_addr == ADDR_W'(CTRL_ADDR));

	// Digit registers
	// Each digit compares the address against its own index
	// Only the low nibble of the write data carries the BCD code
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				cfg.digits[i] <= '0;
			end
		end else if (wr_en) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				if (wr_addr == ADDR_W'(i)) begin
					cfg.digits[i] <= wr_data[3:0];
				end
			end
		end
	end

	// Control register
	// Reset leaves lamp test, blanking and suppression all off
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.lamp_test <= 1'b0;
			cfg.blank_all <= 1'b0;
			cfg.zero_suppress <= 1'b0;
		end else if (ctrl_wr) begin
			cfg.lamp_test <= wr_data[CTRL_LAMP_TEST];
			cfg.blank_all <= wr_data[CTRL_BLANK];
			cfg.zero_suppress <= wr_data[CTRL_ZERO_SUPPRESS];
		end
	end

	// Addresses above the control register match neither block above,
	// so writes there fall through without any effect

endmodule

// File: display_top.sv
// --------------------
// Four-digit display driver top level
// --------------------
`timescale 1ns/1ps

module display_top (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               wr_en,
	input  logic [display_pkg::ADDR_W-1:0]     wr_addr,
	input  logic [7:0]                         wr_data,
	output display_pkg::seg_t                  seg,
	output logic [display_pkg::NUM_DIGITS-1:0] digit_sel
);
	import display_pkg::*;

	// Register contents on their way to the decoders
	display_cfg_if cfg ();

	// Decoded pattern of every digit, ready for scanning
	seg_t patterns [NUM_DIGITS];

	// Host writes land here one cycle after the strobe
	display_regs u_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.cfg     (cfg)
	);

	// Purely combinational decode with leading zero suppression
	blanking_chain u_chain (
		.cfg      (cfg),
		.patterns (patterns)
	);

	// The scanner adds one more register stage, so a write shows
	// within two cycles once its digit comes round, at most
	// NUM_DIGITS times SCAN_DIV cycles later
	scan_mux u_scan (
		.clk       (clk),
		.arst_n    (arst_n),
		.patterns  (patterns),
		.seg       (seg),
		.digit_sel (digit_sel)
	);

endmodule

// File: project.f
display_pkg.sv
display_cfg_if.sv
bcd_seg_decoder.sv
display_regs.sv
blanking_chain.sv
scan_mux.sv
display_top.sv
tb_display_top.sv

// File: scan_mux.sv
// --------------------
// Time-multiplexed digit scanner onto the shared segment bus
// --------------------
`timescale 1ns/1ps

module scan_mux (
	input  logic                               clk,
	input  logic                               arst_n,
	input  display_pkg::seg_t                  patterns [display_pkg::NUM_DIGITS],
	output display_pkg::seg_t                  seg,
	output logic [display_pkg::NUM_DIGITS-1:0] digit_sel
);
	import display_pkg::*;

	// Cycles spent on the current digit
	logic [$clog2(SCAN_DIV)-1:0] presc;

	// Digit currently driven onto the bus
	logic [$clog2(NUM_DIGITS)-1:0] digit_idx;

	// Last cycle of the dwell time on one digit
	logic presc_done;

	// Last digit before wrapping back to digit zero
	logic idx_last;

	assign presc_done = (presc == $bits(presc)'(SCAN_DIV - 1));
	assign idx_last = (digit_idx == $bits(digit_idx)'(NUM_DIGITS - 1));

	// Prescaler, restarts every SCAN_DIV cycles
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			presc <= '0;
		end else if (presc_done) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	// Digit index, steps once per prescaler period
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			digit_idx <= '0;
		end else if (presc_done) begin
			if (idx_last) begin
				digit_idx <= '0;
			end else begin
				digit_idx <= digit_idx + 1'b1;
			end
		end
	end

	// Output stage
	// Pattern and select load on the same edge from the same index,
	// so the bus never shows one digit's segments under another's select
	// The pattern reloads every cycle and tracks register writes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seg <= SEG_OFF;
			// No digit enabled while in reset
			digit_sel <= '1;
		end else begin
			seg <= patterns[digit_idx];
			// One-hot select, active low
			digit_sel <= ~(NUM_DIGITS'(1) << digit_idx);
		end
	end

endmodule

// File: tb_display_top.sv
// --------------------
// Directed testbench for the four-digit display driver
// --------------------
`timescale 1ns/1ps

module tb_display_top;
	import display_pkg::*;

	// Register map as seen by the host
	localparam logic [2:0] CTRL_REG = 3'd4;
	localparam int LAMP_BIT = 0;
	localparam int BLANK_BIT = 1;
	localparam int SUPPRESS_BIT = 2;

	// Longest wait for one digit select is a full scan round plus margin
	localparam int TIMEOUT = 2 * NUM_DIGITS * SCAN_DIV + 4;

	logic clk;
	logic arst_n;
	logic wr_en;
	logic [2:0] wr_addr;
	logic [7:0] wr_data;
	seg_t seg;
	logic [NUM_DIGITS-1:0] digit_sel;

	// Shadow of what the host has written
	logic [3:0] digits_q [NUM_DIGITS];
	logic lamp_q;
	logic blank_q;
	logic supp_q;

	logic [31:0] rng_state;
	int error_count;

	display_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.seg       (seg),
		.digit_sel (digit_sel)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Active-low segment glyphs of the classic decoder with segment a in bit 6
	function automatic seg_t glyph_of(input logic [3:0] code);
		case (code)
			4'd0:    return 7'b000_0001;
			4'd1:    return 7'b100_1111;
			4'd2:    return 7'b001_0010;
			4'd3:    return 7'b000_0110;
			4'd4:    return 7'b100_1100;
			4'd5:    return 7'b010_0100;
			4'd6:    return 7'b110_0000;
			4'd7:    return 7'b000_1111;
			4'd8:    return 7'b000_0000;
			4'd9:    return 7'b000_1100;
			4'd10:   return 7'b111_0010;
			4'd11:   return 7'b110_0110;
			4'd12:   return 7'b101_1100;
			4'd13:   return 7'b011_0100;
			4'd14:   return 7'b111_0000;
			default: return 7'b111_1111;
		endcase
	endfunction

	// Expected pattern of one digit from the suppression rule walked from the top digit down
	function automatic seg_t expected_pattern(input int idx);
		logic suppress;
		seg_t result;
		suppress = supp_q;
		result = 7'h7f;
		for (int i = NUM_DIGITS - 1; i >= idx; i--) begin
			if (blank_q) begin
				result = 7'h7f;
			end else if (lamp_q) begin
				result = 7'h00;
			end else if (suppress && i != 0 && digits_q[i] == 4'd0) begin
				result = 7'h7f;
			end else begin
				result = glyph_of(digits_q[i]);
			end
			// A zero only passes the blanking on while it is itself dark
			suppress = suppress && !lamp_q && (digits_q[i] == 4'd0);
		end
		return result;
	endfunction

	// Linear congruential generator
	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// One-cycle write strobe with inputs changed on the falling edge
	task automatic drive_write(input logic [2:0] addr, input logic [7:0] data);
		@(negedge clk);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge clk);
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
	endtask

	// High nibble carries junk that the register must drop
	task automatic write_digit(input int idx, input logic [3:0] code);
		drive_write(3'(idx), {4'b1010, code});
		digits_q[idx] = code;
	endtask

	task automatic write_ctrl(input logic lamp, input logic blank, input logic supp);
		logic [7:0] data;
		data = '0;
		data[LAMP_BIT] = lamp;
		data[BLANK_BIT] = blank;
		data[SUPPRESS_BIT] = supp;
		drive_write(CTRL_REG, data);
		lamp_q = lamp;
		blank_q = blank;
		supp_q = supp;
	endtask

	// Waits for the select of one digit and samples the segment bus
	task automatic capture_digit(input int idx, output seg_t pattern);
		logic [NUM_DIGITS-1:0] target;
		int waited;
		target = ~(NUM_DIGITS'(1) << idx);
		// One more edge so the output register holds the latest write
		@(negedge clk);
		waited = 0;
		while (digit_sel !== target) begin
			if (waited >= TIMEOUT) begin
				error_count++;
				$display("Timeout: digit %0d was never selected on the scan bus", idx);
				$display("Simulation failed");
				$fatal(1);
			end
			@(negedge clk);
			waited++;
		end
		pattern = seg;
	endtask

	// Compares every digit on the bus with the shadow model
	task automatic check_display();
		seg_t got;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			capture_digit(i, got);
			check_value($sformatf("seg digit %0d", i), got, expected_pattern(i));
		end
	endtask

	task automatic reset_behavior();
		arst_n = 1'b0;
		// The output registers hold their reset values from the first rising edge on
		@(posedge clk);
		repeat (10) begin
			@(negedge clk);
			check_value("seg in reset", seg, 7'h7f);
			check_value("digit_sel in reset", digit_sel, 4'hf);
		end
		arst_n = 1'b1;
		check_value("seg at release", seg, 7'h7f);
		check_value("digit_sel at release", digit_sel, 4'hf);
		// Scanning starts on digit zero
		@(negedge clk);
		check_value("digit_sel first scan", digit_sel, 4'he);
		repeat (NUM_DIGITS * SCAN_DIV) begin
			@(negedge clk);
			check_value("digit_sel one-hot count", $countones(~digit_sel), 1);
		end
	endtask

	task automatic glyph_table_sweep();
		seg_t got;
		write_ctrl(1'b0, 1'b0, 1'b0);
		for (int d = 0; d < NUM_DIGITS; d++) begin
			for (int code = 0; code < 16; code++) begin
				write_digit(d, 4'(code));
				capture_digit(d, got);
				check_value($sformatf("seg digit %0d code %0d", d, code), got,
					glyph_of(4'(code)));
			end
		end
	endtask

	// Digit values are given from digit three down to digit zero
	task automatic write_value(input logic [3:0] d3, input logic [3:0] d2,
			input logic [3:0] d1, input logic [3:0] d0);
		write_digit(3, d3);
		write_digit(2, d2);
		write_digit(1, d1);
		write_digit(0, d0);
	endtask

	task automatic zero_suppression_cases();
		write_ctrl(1'b0, 1'b0, 1'b1);
		write_value(4'd0, 4'd0, 4'd4, 4'd0);
		check_display();
		// All zeros still leave one zero on digit zero
		write_value(4'd0, 4'd0, 4'd0, 4'd0);
		check_display();
		write_value(4'd9, 4'd0, 4'd0, 4'd1);
		check_display();
	endtask

	task automatic lamp_test_override();
		write_value(4'd0, 4'd0, 4'd0, 4'd15);
		write_ctrl(1'b1, 1'b0, 1'b1);
		check_display();
		write_ctrl(1'b0, 1'b0, 1'b1);
		check_display();
	endtask

	task automatic blank_priority();
		write_value(4'd1, 4'd2, 4'd3, 4'd4);
		write_ctrl(1'b1, 1'b1, 1'b1);
		check_display();
		write_ctrl(1'b0, 1'b1, 1'b0);
		check_display();
		// Clearing blank brings the stored digits back
		write_ctrl(1'b0, 1'b0, 1'b1);
		check_display();
	endtask

	task automatic random_values();
		logic [31:0] r;
		write_ctrl(1'b0, 1'b0, 1'b1);
		for (int n = 0; n < 20; n++) begin
			for (int d = NUM_DIGITS - 1; d >= 0; d--) begin
				r = lcg_next();
				// Zeros come up often so suppression gets exercised
				if (r[25:24] == 2'b00) begin
					write_digit(d, 4'd0);
				end else begin
					write_digit(d, 4'((r >> 8) % 10));
				end
			end
			check_display();
		end
	endtask

	initial begin
		arst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rng_state = 32'd7577;
		error_count = 0;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			digits_q[i] = 4'd0;
		end
		lamp_q = 1'b0;
		blank_q = 1'b0;
		supp_q = 1'b0;

		reset_behavior();
		glyph_table_sweep();
		zero_suppression_cases();
		lamp_test_override();
		blank_priority();
		random_values();

		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
